// ==== verilog/platform_pkg.sv ====
// bus widths, address map and register offsets shared by the peripheral platform
// imported by every RTL block and by the testbench
package platform_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // slave indices into the decoder arrays
    localparam int NUM_SLAVES             = 3;
    localparam int RAM_SLAVE_INDEX        = 0;
    localparam int MTIMER_SLAVE_INDEX     = 1;
    localparam int LED_DRIVER_SLAVE_INDEX = 2;

    // a slave hits when the address anded with its mask equals its base
    localparam logic [ADDR_W-1:0] START_ADDRESS [NUM_SLAVES] = '{
        RAM_SLAVE_INDEX:        32'h0000_0000,
        MTIMER_SLAVE_INDEX:     32'h0001_0000,
        LED_DRIVER_SLAVE_INDEX: 32'h0002_0000
    };
    localparam logic [ADDR_W-1:0] MASK [NUM_SLAVES] = '{
        RAM_SLAVE_INDEX:        32'hFFFF_0000,
        MTIMER_SLAVE_INDEX:     32'hFFFF_0000,
        LED_DRIVER_SLAVE_INDEX: 32'hFFFF_0000
    };

    // mtimer register offsets inside its window
    localparam logic [ADDR_W-1:0] MTIME_LO_OFS    = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] MTIME_HI_OFS    = 32'h0000_0004;
    localparam logic [ADDR_W-1:0] MTIMECMP_LO_OFS = 32'h0000_0008;
    localparam logic [ADDR_W-1:0] MTIMECMP_HI_OFS = 32'h0000_000C;

    // replace the bytes of old_word that sel enables
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [SEL_W-1:0]  sel
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage: platform_pkg

// ==== verilog/wb_interconnect.sv ====
`timescale 1ns/1ps
// wishbone address decoder, one master to NUM_SLAVES slaves
// combinational request path with a registered err for unmapped requests
module wb_interconnect
import platform_pkg::*;
#(
    parameter int                NUM_SLAVES                 = platform_pkg::NUM_SLAVES,
    parameter logic [ADDR_W-1:0] START_ADDRESS [NUM_SLAVES] = platform_pkg::START_ADDRESS,
    parameter logic [ADDR_W-1:0] MASK [NUM_SLAVES]          = platform_pkg::MASK
)
(
    input  logic                  clk_i,
    input  logic                  arst_n_i,

    // master side
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic [ADDR_W-1:0]     wb_addr_i,
    output logic [DATA_W-1:0]     wb_rdata_o,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,

    // slave side
    output logic [NUM_SLAVES-1:0] slv_stb_o,
    input  logic [NUM_SLAVES-1:0] slv_ack_i,
    input  logic [DATA_W-1:0]     slv_rdata_i [NUM_SLAVES]
);

    localparam int IDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    logic                  req;
    logic [NUM_SLAVES-1:0] match;
    logic                  hit;
    logic [IDX_W-1:0]      hit_idx;
    logic [IDX_W-1:0]      sel_q;
    logic                  err_q;

    assign req = wb_cyc_i & wb_stb_i;

    // one compare per address window
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            match[i] = ((wb_addr_i & MASK[i]) == START_ADDRESS[i]);
        end
    end

    assign hit = |match;

    // index of the matching window
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (match[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    // strobe the slaves whose window matches
    assign slv_stb_o = req ? match : '0;

    // select held for the return path, err for misses
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= '0;
            err_q <= 1'b0;
        end else begin
            if (req && hit) begin
                sel_q <= hit_idx;
            end
            // one err pulse per unmapped request
            err_q <= req & ~hit & ~err_q;
        end
    end

    // return path from the selected slave
    assign wb_ack_o   = slv_ack_i[sel_q];
    assign wb_err_o   = err_q;
    // zero data on err
    assign wb_rdata_o = err_q ? '0 : slv_rdata_i[sel_q];

    // overlapping windows would strobe two slaves
    a_stb_onehot0: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(slv_stb_o)
    ) else $error("more than one slave strobed");

    // slave ack and decoder err are exclusive
    a_ack_err_excl: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !(wb_ack_o && wb_err_o)
    ) else $error("ack and err high together");

endmodule: wb_interconnect

// ==== verilog/scratch_ram.sv ====
`timescale 1ns/1ps
// word-addressed scratch data RAM on the wishbone bus
// byte selects on write, registered read data and ack one cycle after stb
module scratch_ram
import platform_pkg::*;
#(
    // power of two, address wraps modulo this depth
    parameter int RAM_WORDS = 256
)
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              ack_o
);

    localparam int WORD_AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [DATA_W-1:0]  mem [RAM_WORDS];
    logic [WORD_AW-1:0] word_idx;
    logic               access;
    logic               ack_q;
    logic [DATA_W-1:0]  rdata_q;

    // word index above the byte offset
    assign word_idx = addr_i[WORD_AW+1:2];
    // act once per request, not again while stb still held
    assign access   = stb_i & ~ack_q;

    // storage and read port
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[word_idx];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

    // ack only follows a strobe
    a_ack_after_stb: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ack_o |-> $past(stb_i)
    ) else $error("ram ack without preceding stb");

endmodule: scratch_ram

// ==== verilog/mtimer.sv ====
`timescale 1ns/1ps
// machine timer slave, 64-bit mtime and mtimecmp as word pairs on the bus
// timer_irq_o is a registered level while mtime >= mtimecmp
module mtimer
import platform_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  logic              stb_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              ack_o,

    output logic              timer_irq_o
);

    logic [63:0]       mtime_q;
    logic [63:0]       mtimecmp_q;
    logic [1:0]        reg_sel;
    logic              access;
    logic              wr;
    logic              ack_q;
    logic              irq_q;
    logic [DATA_W-1:0] rdata_q;

    // word offset within the window
    assign reg_sel = addr_i[3:2];
    // one action per request
    assign access  = stb_i & ~ack_q;
    assign wr      = access & we_i;

    // mtime free runs, a write replaces the increment on that edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q <= '0;
        end else if (wr && (reg_sel == MTIME_LO_OFS[3:2])) begin
            mtime_q[31:0] <= merge_bytes(mtime_q[31:0], wdata_i, sel_i);
        end else if (wr && (reg_sel == MTIME_HI_OFS[3:2])) begin
            mtime_q[63:32] <= merge_bytes(mtime_q[63:32], wdata_i, sel_i);
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // all ones at reset so nothing is pending
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtimecmp_q <= '1;
        end else if (wr && (reg_sel == MTIMECMP_LO_OFS[3:2])) begin
            mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], wdata_i, sel_i);
        end else if (wr && (reg_sel == MTIMECMP_HI_OFS[3:2])) begin
            mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], wdata_i, sel_i);
        end
    end

    // read data captured with the request
    always_ff @(posedge clk_i) begin
        if (access) begin
            case (reg_sel)
                MTIME_LO_OFS[3:2]:    rdata_q <= mtime_q[31:0];
                MTIME_HI_OFS[3:2]:    rdata_q <= mtime_q[63:32];
                MTIMECMP_LO_OFS[3:2]: rdata_q <= mtimecmp_q[31:0];
                default:              rdata_q <= mtimecmp_q[63:32];
            endcase
        end
    end

    // ack and interrupt
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            irq_q <= 1'b0;
        end else begin
            ack_q <= access;
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign ack_o       = ack_q;
    assign rdata_o     = rdata_q;
    assign timer_irq_o = irq_q;

    // quiet right after reset, relies on the mtimecmp reset value
    a_irq_low_after_reset: assert property (
        @(posedge clk_i)
        $rose(arst_n_i) |-> !timer_irq_o ##1 !timer_irq_o
    ) else $error("timer irq pending after reset");

endmodule: mtimer

// ==== verilog/led_driver.sv ====
`timescale 1ns/1ps
// eight-bit LED status register on the wishbone bus
// low byte of a write with sel bit 0 loads the LEDs, reads return it zero-extended
module led_driver
import platform_pkg::*;
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    input  logic              stb_i,
    input  logic              we_i,
    input  logic [SEL_W-1:0]  sel_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              ack_o,

    output logic [7:0]        led_status_o
);

    logic       access;
    logic       ack_q;
    logic [7:0] led_q;

    // address ignored, whole window maps to the one register
    assign access = stb_i & ~ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            led_q <= '0;
        end else begin
            ack_q <= access;
            // only the low byte lane counts
            if (access && we_i && sel_i[0]) begin
                led_q <= wdata_i[7:0];
            end
        end
    end

    assign ack_o        = ack_q;
    // register is live, so read data is ready with the ack
    assign rdata_o      = {{(DATA_W-8){1'b0}}, led_q};
    assign led_status_o = led_q;

endmodule: led_driver

// ==== verilog/periph_platform.sv ====
`timescale 1ns/1ps
// peripheral platform top, one external wishbone master to RAM, mtimer and LEDs
module periph_platform
import platform_pkg::*;
#(
    parameter int RAM_WORDS = 256
)
(
    input  logic              clk_i,
    input  logic              arst_n_i,

    // external master
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_addr_i,
    input  logic [SEL_W-1:0]  wb_sel_i,
    input  logic [DATA_W-1:0] wb_wdata_i,
    output logic [DATA_W-1:0] wb_rdata_o,
    output logic              wb_ack_o,
    output logic              wb_err_o,

    // peripherals
    output logic              timer_irq_o,
    output logic [7:0]        led_status_o
);

    // per-slave strobe, ack and read data
    logic [NUM_SLAVES-1:0] slv_stb;
    logic [NUM_SLAVES-1:0] slv_ack;
    logic [DATA_W-1:0]     slv_rdata [NUM_SLAVES];

    // decoder
    wb_interconnect
    #(.NUM_SLAVES(NUM_SLAVES), .START_ADDRESS(START_ADDRESS), .MASK(MASK))
    u_wb_interconnect (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_addr_i   (wb_addr_i),
        .wb_rdata_o  (wb_rdata_o),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .slv_stb_o   (slv_stb),
        .slv_ack_i   (slv_ack),
        .slv_rdata_i (slv_rdata)
    );

    // scratch data memory
    scratch_ram #(.RAM_WORDS(RAM_WORDS)) u_scratch_ram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .stb_i    (slv_stb[RAM_SLAVE_INDEX]),
        .we_i     (wb_we_i),
        .addr_i   (wb_addr_i),
        .sel_i    (wb_sel_i),
        .wdata_i  (wb_wdata_i),
        .rdata_o  (slv_rdata[RAM_SLAVE_INDEX]),
        .ack_o    (slv_ack[RAM_SLAVE_INDEX])
    );

    // machine timer
    mtimer u_mtimer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .stb_i       (slv_stb[MTIMER_SLAVE_INDEX]),
        .we_i        (wb_we_i),
        .addr_i      (wb_addr_i),
        .sel_i       (wb_sel_i),
        .wdata_i     (wb_wdata_i),
        .rdata_o     (slv_rdata[MTIMER_SLAVE_INDEX]),
        .ack_o       (slv_ack[MTIMER_SLAVE_INDEX]),
        .timer_irq_o (timer_irq_o)
    );

    // led status register
    led_driver u_led_driver (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .stb_i        (slv_stb[LED_DRIVER_SLAVE_INDEX]),
        .we_i         (wb_we_i),
        .sel_i        (wb_sel_i),
        .wdata_i      (wb_wdata_i),
        .rdata_o      (slv_rdata[LED_DRIVER_SLAVE_INDEX]),
        .ack_o        (slv_ack[LED_DRIVER_SLAVE_INDEX]),
        .led_status_o (led_status_o)
    );

endmodule: periph_platform

// ==== verif/tb_periph_platform.sv ====
`timescale 1ns/1ps
// testbench for the peripheral platform acting as the external wishbone master
// table-driven RAM, err and LED accesses then directed mtime and timer irq sequences
module tb_periph_platform
import platform_pkg::*;
();

    localparam int N_ENTRIES   = 22;
    // 40 cycles per table entry plus room for the directed tests
    localparam int CYCLE_LIMIT = N_ENTRIES * 40 + 500;
    localparam int RESP_LIMIT  = 8;
    localparam logic [31:0] LED_BASE = START_ADDRESS[LED_DRIVER_SLAVE_INDEX];
    localparam logic [31:0] TMR_BASE = START_ADDRESS[MTIMER_SLAVE_INDEX];

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        ack;
    logic        err;
    logic        timer_irq;
    logic [7:0]  led_status;

    // stimulus table, one access per entry
    logic        t_we    [N_ENTRIES];
    logic [31:0] t_addr  [N_ENTRIES];
    logic [3:0]  t_sel   [N_ENTRIES];
    logic [31:0] t_wdata [N_ENTRIES];
    logic [31:0] t_exp   [N_ENTRIES];
    logic        t_err   [N_ENTRIES];
    int          t_id    [N_ENTRIES];
    int          n_fill = 0;

    int cycles   = 0;
    int checks   = 0;
    int cur_test = 0;
    int errs [1:5];

    periph_platform #(.RAM_WORDS(256)) u_dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .wb_cyc_i     (cyc),
        .wb_stb_i     (stb),
        .wb_we_i      (we),
        .wb_addr_i    (addr),
        .wb_sel_i     (sel),
        .wb_wdata_i   (wdata),
        .wb_rdata_o   (rdata),
        .wb_ack_o     (ack),
        .wb_err_o     (err),
        .timer_irq_o  (timer_irq),
        .led_status_o (led_status)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // 32-bit lcg step
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte lanes enabled by s come from nw and the rest stay old
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                                input logic [31:0] nw,
                                                input logic [3:0] s);
        logic [31:0] lane_mask;
        lane_mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
        return (old_w & ~lane_mask) | (nw & lane_mask);
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1:       return "ram read/write";
            2:       return "unmapped err";
            3:       return "led register";
            4:       return "mtime counting";
            default: return "timer irq";
        endcase
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns: test %0d %s, got %08h expected %08h",
                     $time, cur_test, what, got, exp);
            errs[cur_test]++;
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            $display("[FAIL] %0t ns: test %0d %s", $time, cur_test, what);
            errs[cur_test]++;
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %s, %0d errors", id, test_label(id),
                 (errs[id] == 0) ? "ok" : "failed", errs[id]);
    endtask

    // one classic wishbone cycle starting on the next falling edge
    task automatic bus_access(input logic a_we, input logic [31:0] a_addr,
                              input logic [3:0] a_sel, input logic [31:0] a_wdata,
                              output logic [31:0] a_rdata, output logic a_ack,
                              output logic a_err);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = a_we;
        addr  = a_addr;
        sel   = a_sel;
        wdata = a_wdata;
        // bounded wait for ack or err
        do begin
            @(negedge clk);
            waited++;
        end while (!(ack || err) && waited < RESP_LIMIT);
        a_rdata = rdata;
        a_ack   = ack;
        a_err   = err;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        checks++;
        assert (a_ack || a_err) else begin
            $display("test %0d: no ack or err for address %08h within %0d cycles",
                     cur_test, a_addr, waited);
            errs[cur_test]++;
        end
        if (a_ack || a_err) begin
            check_true("response on the edge after the request", waited == 1);
        end
        check_true("ack and err exclusive", !(a_ack && a_err));
        // response is a one-cycle pulse
        @(negedge clk);
        check_true("no second ack or err", !(ack || err));
    endtask

    task automatic add_entry(input int id, input logic e_we, input logic [31:0] e_addr,
                             input logic [3:0] e_sel, input logic [31:0] e_wdata,
                             input logic [31:0] e_exp, input logic e_err);
        t_id[n_fill]    = id;
        t_we[n_fill]    = e_we;
        t_addr[n_fill]  = e_addr;
        t_sel[n_fill]   = e_sel;
        t_wdata[n_fill] = e_wdata;
        t_exp[n_fill]   = e_exp;
        t_err[n_fill]   = e_err;
        n_fill++;
    endtask

    // expected values fixed before any access
    task automatic fill_table();
        logic [31:0] seed;
        logic [31:0] w [4];
        logic [31:0] ram_addr [4];
        seed     = 32'd87;
        ram_addr = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0040, 32'h0000_03FC};
        for (int i = 0; i < 4; i++) begin
            seed = lcg_next(seed);
            w[i] = seed;
            add_entry(1, 1'b1, ram_addr[i], 4'hF, w[i], 32'h0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry(1, 1'b0, ram_addr[i], 4'hF, 32'h0, w[i], 1'b0);
        end
        // partial writes merge the old word with the new lanes
        seed = lcg_next(seed);
        add_entry(1, 1'b1, ram_addr[1], 4'b0101, seed, 32'h0, 1'b0);
        add_entry(1, 1'b0, ram_addr[1], 4'hF, 32'h0, merge_lanes(w[1], seed, 4'b0101), 1'b0);
        seed = lcg_next(seed);
        add_entry(1, 1'b1, ram_addr[2], 4'b1000, seed, 32'h0, 1'b0);
        add_entry(1, 1'b0, ram_addr[2], 4'hF, 32'h0, merge_lanes(w[2], seed, 4'b1000), 1'b0);
        // unmapped space that would alias RAM word 0 if decoded wrongly
        add_entry(2, 1'b1, 32'h0003_0000, 4'hF, ~w[0], 32'h0, 1'b1);
        add_entry(2, 1'b0, 32'h0003_0004, 4'hF, 32'h0, 32'h0, 1'b1);
        add_entry(2, 1'b1, 32'hFFFF_FF00, 4'hF, 32'h1234_5678, 32'h0, 1'b1);
        add_entry(2, 1'b0, ram_addr[0], 4'hF, 32'h0, w[0], 1'b0);
        // led register where sel bit 0 gates the load
        add_entry(3, 1'b0, LED_BASE, 4'hF, 32'h0, 32'h0, 1'b0);
        add_entry(3, 1'b1, LED_BASE, 4'b0001, 32'h0000_00A5, 32'h0, 1'b0);
        add_entry(3, 1'b0, LED_BASE, 4'hF, 32'h0, 32'h0000_00A5, 1'b0);
        add_entry(3, 1'b1, LED_BASE, 4'b1110, 32'h5A5A_5A3C, 32'h0, 1'b0);
        add_entry(3, 1'b0, LED_BASE, 4'hF, 32'h0, 32'h0000_00A5, 1'b0);
        add_entry(3, 1'b0, LED_BASE + 32'h10, 4'hF, 32'h0, 32'h0000_00A5, 1'b0);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] now;
        logic        got_ack;
        logic        got_err;
        int          t0;
        int          total;
        arst_n = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        sel    = '0;
        wdata  = '0;
        for (int t = 1; t <= 5; t++) begin
            errs[t] = 0;
        end
        fill_table();

        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        cur_test = 3;
        check_equal("led pins after reset", {24'h0, led_status}, 32'h0);
        cur_test = 5;
        check_true("timer irq low after reset", timer_irq === 1'b0);

        for (int i = 0; i < n_fill; i++) begin
            cur_test = t_id[i];
            bus_access(t_we[i], t_addr[i], t_sel[i], t_wdata[i], rd, got_ack, got_err);
            check_true("err as expected", got_err === t_err[i]);
            check_true("ack as expected", got_ack === !t_err[i]);
            if (!t_we[i]) begin
                check_equal($sformatf("read %08h", t_addr[i]), rd, t_exp[i]);
                // pins follow the register
                if (!t_err[i] && (t_addr[i] & MASK[LED_DRIVER_SLAVE_INDEX]) == LED_BASE) begin
                    check_equal("led pins", {24'h0, led_status}, t_exp[i]);
                end
            end
            if (i == n_fill - 1 || t_id[i + 1] != t_id[i]) begin
                report_test(t_id[i]);
            end
        end

        // mtime free runs and then restarts from zero
        cur_test = 4;
        bus_access(1'b0, TMR_BASE + MTIME_LO_OFS, 4'hF, 32'h0, v0, got_ack, got_err);
        bus_access(1'b0, TMR_BASE + MTIME_LO_OFS, 4'hF, 32'h0, v1, got_ack, got_err);
        check_true("mtime_lo increases between reads", v1 > v0);
        // nonzero high word so that clearing it is visible
        bus_access(1'b1, TMR_BASE + MTIME_HI_OFS, 4'hF, 32'h0000_A5A5, rd, got_ack, got_err);
        bus_access(1'b0, TMR_BASE + MTIME_HI_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        check_equal("mtime_hi after writing", rd, 32'h0000_A5A5);
        bus_access(1'b1, TMR_BASE + MTIME_LO_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        t0 = cycles;
        bus_access(1'b1, TMR_BASE + MTIME_HI_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        bus_access(1'b0, TMR_BASE + MTIME_LO_OFS, 4'hF, 32'h0, v1, got_ack, got_err);
        check_true("mtime_lo nonzero after clearing", v1 != 32'h0);
        check_true("mtime_lo below cycles since clearing", v1 < (cycles - t0));
        bus_access(1'b0, TMR_BASE + MTIME_HI_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        check_equal("mtime_hi after clearing", rd, 32'h0);
        report_test(4);

        // compare 200 ticks ahead and then disarm
        cur_test = 5;
        bus_access(1'b0, TMR_BASE + MTIMECMP_HI_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        check_equal("mtimecmp_hi reset value", rd, 32'hFFFF_FFFF);
        bus_access(1'b0, TMR_BASE + MTIME_LO_OFS, 4'hF, 32'h0, now, got_ack, got_err);
        bus_access(1'b1, TMR_BASE + MTIMECMP_HI_OFS, 4'hF, 32'h0, rd, got_ack, got_err);
        bus_access(1'b1, TMR_BASE + MTIMECMP_LO_OFS, 4'hF, now + 32'd200, rd, got_ack, got_err);
        check_true("irq low right after arming", timer_irq === 1'b0);
        repeat (250) @(negedge clk);
        check_true("irq high once mtime reaches mtimecmp", timer_irq === 1'b1);
        bus_access(1'b1, TMR_BASE + MTIMECMP_HI_OFS, 4'hF, 32'hFFFF_FFFF, rd, got_ack, got_err);
        check_true("irq cleared by mtimecmp_hi all ones", timer_irq === 1'b0);
        report_test(5);

        total = 0;
        for (int t = 1; t <= 5; t++) begin
            total += errs[t];
        end
        $display("tests: 5, checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule: tb_periph_platform

// ==== sources.f ====
verilog/platform_pkg.sv
verilog/wb_interconnect.sv
verilog/scratch_ram.sv
verilog/mtimer.sv
verilog/led_driver.sv
verilog/periph_platform.sv
verif/tb_periph_platform.sv

// ==== Bender.yml ====
package:
  name: periph_platform

sources:
  - files:
      - verilog/platform_pkg.sv
      - verilog/wb_interconnect.sv
      - verilog/scratch_ram.sv
      - verilog/mtimer.sv
      - verilog/led_driver.sv
      - verilog/periph_platform.sv
  - target: test
    files:
      - verif/tb_periph_platform.sv
